/* verilog/csr_pkg.sv */
package csr_pkg;

  localparam int CSR_WIDTH = 32;

  typedef logic [CSR_WIDTH-1:0] csr_word_t;
  typedef logic [11:0]          csr_addr_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1, // Not implemented, legalized away
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_op_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vector_mode_t;

  // Machine trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;

  // Counters, machine and user views
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  localparam csr_addr_t CYCLE_ADDR         = 12'hC00;
  localparam csr_addr_t INSTRET_ADDR       = 12'hC02;
  localparam csr_addr_t CYCLEH_ADDR        = 12'hC80;
  localparam csr_addr_t INSTRETH_ADDR      = 12'hC82;

  // Machine information, read only
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR    = 12'hF15;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;
  localparam int MSTATUS_MPP_HI   = 12;
  localparam int MSTATUS_MPRV_BIT = 17;
  localparam int MSTATUS_TW_BIT   = 21;

  localparam int MSI_BIT = 3; // Same positions in mie and mip
  localparam int MTI_BIT = 7;
  localparam int MEI_BIT = 11;

  localparam int COUNT_CY_BIT = 0; // mcounteren and mcountinhibit
  localparam int COUNT_IR_BIT = 2;

  localparam csr_word_t MSTATUS_RESET = (csr_word_t'(1) << MSTATUS_TW_BIT)
                                      | (csr_word_t'(U_MODE) << MSTATUS_MPP_LO);
  localparam csr_word_t MCOUNTEREN_RESET = '1;

endpackage

/* verilog/csr_access_unit.sv */
module csr_access_unit import csr_pkg::*; (
  input  csr_addr_t   csr_addr,
  input  csr_op_t     csr_op,
  input  logic        read_only,
  input  logic        write_valid,
  input  csr_word_t   new_csr_val,
  input  csr_word_t   old_csr_val,
  input  priv_level_t curr_priv,
  output csr_word_t   nxt_csr_val,
  output logic        wr_en,
  output logic        invalid_priv
);

  logic csr_active;
  logic ro_violation;
  logic priv_violation;

  assign csr_active = (csr_op != CSR_NONE);

  // Top two address bits of 11 mark a read-only CSR
  assign ro_violation = (csr_addr[11:10] == 2'b11) && !read_only;

  // Bits 9:8 give the lowest privilege allowed to touch the CSR
  assign priv_violation = (csr_addr[9:8] > curr_priv);

  assign invalid_priv = csr_active && (ro_violation || priv_violation);

  always_comb begin
    case (csr_op)
      CSR_WRITE: nxt_csr_val = new_csr_val;
      CSR_SET:   nxt_csr_val = old_csr_val | new_csr_val;
      CSR_CLEAR: nxt_csr_val = old_csr_val & ~new_csr_val;
      default:   nxt_csr_val = old_csr_val; // Nothing to modify
    endcase
  end

  // A set or clear with a zero source only reads
  assign wr_en = write_valid && csr_active && !read_only && !invalid_priv;

endmodule

/* verilog/csr_machine_regs.sv */
module csr_machine_regs import csr_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  csr_addr_t csr_addr,
  input  logic      wr_en,
  input  csr_word_t nxt_csr_val,
  input  csr_word_t new_csr_val,
  input  logic      inject_mstatus,
  input  logic      inject_mepc,
  input  logic      inject_mcause,
  input  logic      inject_mtval,
  input  logic      inject_mip,
  input  csr_word_t next_mstatus,
  input  csr_word_t next_mepc,
  input  csr_word_t next_mcause,
  input  csr_word_t next_mtval,
  input  csr_word_t next_mip,
  output csr_word_t mstatus,
  output csr_word_t mtvec,
  output csr_word_t mie,
  output csr_word_t mip,
  output csr_word_t mscratch,
  output csr_word_t mepc,
  output csr_word_t mcause,
  output csr_word_t mtval
);

  // Writable mstatus bits apart from MPP, which is legalized on its own
  localparam csr_word_t MSTATUS_WR_MASK = (csr_word_t'(1) << MSTATUS_MIE_BIT)
                                        | (csr_word_t'(1) << MSTATUS_MPIE_BIT)
                                        | (csr_word_t'(1) << MSTATUS_MPRV_BIT)
                                        | (csr_word_t'(1) << MSTATUS_TW_BIT);
  localparam csr_word_t M_INT_MASK = (csr_word_t'(1) << MSI_BIT)
                                   | (csr_word_t'(1) << MTI_BIT)
                                   | (csr_word_t'(1) << MEI_BIT);

  csr_word_t    mstatus_next, mtvec_next, mie_next, mip_next;
  csr_word_t    mscratch_next, mepc_next, mcause_next, mtval_next;
  priv_level_t  mpp_legal;
  vector_mode_t tvec_mode;

  always_comb begin
    mpp_legal = priv_level_t'(nxt_csr_val[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
    // Only M and U exist, so S and the reserved code both drop to U
    if (new_csr_val[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == RESERVED_MODE ||
        new_csr_val[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == S_MODE) begin
      mpp_legal = U_MODE;
    end
  end

  always_comb begin
    if (nxt_csr_val[1:0] > VECTORED) begin
      tvec_mode = DIRECT; // Reserved modes
    end else begin
      tvec_mode = vector_mode_t'(nxt_csr_val[1:0]);
    end
  end

  always_comb begin
    mstatus_next  = mstatus;
    mtvec_next    = mtvec;
    mie_next      = mie;
    mip_next      = mip;
    mscratch_next = mscratch;
    mepc_next     = mepc;
    mcause_next   = mcause;
    mtval_next    = mtval;

    if (wr_en) begin
      case (csr_addr)
        MSTATUS_ADDR: begin
          mstatus_next = nxt_csr_val & MSTATUS_WR_MASK;
          mstatus_next[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mpp_legal;
        end
        MTVEC_ADDR:    mtvec_next = {nxt_csr_val[CSR_WIDTH-1:2], tvec_mode};
        MIE_ADDR:      mie_next = nxt_csr_val & M_INT_MASK;
        MIP_ADDR:      mip_next = nxt_csr_val & M_INT_MASK;
        MSCRATCH_ADDR: mscratch_next = nxt_csr_val;
        MEPC_ADDR:     mepc_next = nxt_csr_val;
        MCAUSE_ADDR:   mcause_next = nxt_csr_val;
        MTVAL_ADDR:    mtval_next = nxt_csr_val;
        default: ;
      endcase
    end

    // Trap handler updates win over the instruction
    if (inject_mstatus) begin
      mstatus_next = next_mstatus;
    end
    if (inject_mepc) begin
      mepc_next = next_mepc;
    end
    if (inject_mcause) begin
      mcause_next = next_mcause;
    end
    if (inject_mtval) begin
      mtval_next = next_mtval;
    end
    if (inject_mip) begin
      mip_next = next_mip;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus  <= MSTATUS_RESET; // TW set, MPP at U
      mtvec    <= '0;
      mie      <= '0;
      mip      <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else begin
      mstatus  <= mstatus_next;
      mtvec    <= mtvec_next;
      mie      <= mie_next;
      mip      <= mip_next;
      mscratch <= mscratch_next;
      mepc     <= mepc_next;
      mcause   <= mcause_next;
      mtval    <= mtval_next;
    end
  end

endmodule

/* verilog/csr_counters.sv */
module csr_counters import csr_pkg::*; (
  input  logic                     CLK,
  input  logic                     nRST,
  input  csr_addr_t                csr_addr,
  input  logic                     wr_en,
  input  csr_word_t                nxt_csr_val,
  input  logic                     inst_ret,
  output logic [2*CSR_WIDTH-1:0]   cycle_full,
  output logic [2*CSR_WIDTH-1:0]   instret_full,
  output csr_word_t                mcounteren,
  output csr_word_t                mcountinhibit
);

  // Only the cycle and instret inhibits exist
  localparam csr_word_t INHIBIT_MASK = (csr_word_t'(1) << COUNT_CY_BIT)
                                     | (csr_word_t'(1) << COUNT_IR_BIT);

  logic [2*CSR_WIDTH-1:0] cycle_next, instret_next;
  csr_word_t              mcounteren_next, mcountinhibit_next;

  always_comb begin
    cycle_next         = cycle_full;
    instret_next       = instret_full;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (!mcountinhibit[COUNT_CY_BIT]) begin
      cycle_next = cycle_full + 1'b1;
    end
    if (!mcountinhibit[COUNT_IR_BIT]) begin
      instret_next = instret_full + {{(2*CSR_WIDTH-1){1'b0}}, inst_ret};
    end

    // A half written this cycle replaces the increment
    if (wr_en) begin
      case (csr_addr)
        MCYCLE_ADDR:    cycle_next = {cycle_full[2*CSR_WIDTH-1:CSR_WIDTH], nxt_csr_val};
        MCYCLEH_ADDR:   cycle_next = {nxt_csr_val, cycle_full[CSR_WIDTH-1:0]};
        MINSTRET_ADDR:  instret_next = {instret_full[2*CSR_WIDTH-1:CSR_WIDTH], nxt_csr_val};
        MINSTRETH_ADDR: instret_next = {nxt_csr_val, instret_full[CSR_WIDTH-1:0]};
        MCOUNTEREN_ADDR:    mcounteren_next = nxt_csr_val;
        MCOUNTINHIBIT_ADDR: mcountinhibit_next = nxt_csr_val & INHIBIT_MASK;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle_full    <= '0;
      instret_full  <= '0;
      mcounteren    <= MCOUNTEREN_RESET; // User counters visible out of reset
      mcountinhibit <= '0;
    end else begin
      cycle_full    <= cycle_next;
      instret_full  <= instret_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
    end
  end

endmodule

/* verilog/csr_read_mux.sv */
module csr_read_mux import csr_pkg::*; #(
  parameter int HART_ID = 0
) (
  input  csr_addr_t              csr_addr,
  input  csr_op_t                csr_op,
  input  priv_level_t            curr_priv,
  input  csr_word_t              mstatus,
  input  csr_word_t              mtvec,
  input  csr_word_t              mie,
  input  csr_word_t              mip,
  input  csr_word_t              mscratch,
  input  csr_word_t              mepc,
  input  csr_word_t              mcause,
  input  csr_word_t              mtval,
  input  logic [2*CSR_WIDTH-1:0] cycle_full,
  input  logic [2*CSR_WIDTH-1:0] instret_full,
  input  csr_word_t              mcounteren,
  input  csr_word_t              mcountinhibit,
  output csr_word_t              old_csr_val,
  output logic                   invalid_addr
);

  logic csr_active;
  logic cy_denied;
  logic ir_denied;

  assign csr_active = (csr_op != CSR_NONE);

  // User code sees a counter only when mcounteren grants it
  assign cy_denied = csr_active && (curr_priv == U_MODE) && !mcounteren[COUNT_CY_BIT];
  assign ir_denied = csr_active && (curr_priv == U_MODE) && !mcounteren[COUNT_IR_BIT];

  always_comb begin
    old_csr_val  = '0;
    invalid_addr = 1'b0;
    case (csr_addr)
      MVENDORID_ADDR,
      MARCHID_ADDR,
      MIMPID_ADDR,
      MCONFIGPTR_ADDR:    old_csr_val = '0;
      MHARTID_ADDR:       old_csr_val = csr_word_t'(HART_ID);
      MSTATUS_ADDR:       old_csr_val = mstatus;
      MTVEC_ADDR:         old_csr_val = mtvec;
      MIE_ADDR:           old_csr_val = mie;
      MIP_ADDR:           old_csr_val = mip;
      MSCRATCH_ADDR:      old_csr_val = mscratch;
      MEPC_ADDR:          old_csr_val = mepc;
      MCAUSE_ADDR:        old_csr_val = mcause;
      MTVAL_ADDR:         old_csr_val = mtval;
      MCOUNTEREN_ADDR:    old_csr_val = mcounteren;
      MCOUNTINHIBIT_ADDR: old_csr_val = mcountinhibit;
      MCYCLE_ADDR, CYCLE_ADDR: begin
        if (cy_denied) invalid_addr = 1'b1;
        else old_csr_val = cycle_full[CSR_WIDTH-1:0];
      end
      MCYCLEH_ADDR, CYCLEH_ADDR: begin
        if (cy_denied) invalid_addr = 1'b1;
        else old_csr_val = cycle_full[2*CSR_WIDTH-1:CSR_WIDTH];
      end
      MINSTRET_ADDR, INSTRET_ADDR: begin
        if (ir_denied) invalid_addr = 1'b1;
        else old_csr_val = instret_full[CSR_WIDTH-1:0];
      end
      MINSTRETH_ADDR, INSTRETH_ADDR: begin
        if (ir_denied) invalid_addr = 1'b1;
        else old_csr_val = instret_full[2*CSR_WIDTH-1:CSR_WIDTH];
      end
      default: invalid_addr = csr_active; // Unimplemented CSR
    endcase
  end

endmodule

/* verilog/csr_file_top.sv */
module csr_file_top import csr_pkg::*; #(
  parameter int HART_ID = 0
) (
  input  logic        CLK,
  input  logic        nRST,
  input  csr_addr_t   csr_addr,
  input  csr_op_t     csr_op,
  input  logic        read_only,
  input  logic        write_valid,
  input  csr_word_t   new_csr_val,
  input  priv_level_t curr_priv,
  input  logic        inst_ret,
  input  logic        inject_mstatus,
  input  logic        inject_mepc,
  input  logic        inject_mcause,
  input  logic        inject_mtval,
  input  logic        inject_mip,
  input  csr_word_t   next_mstatus,
  input  csr_word_t   next_mepc,
  input  csr_word_t   next_mcause,
  input  csr_word_t   next_mtval,
  input  csr_word_t   next_mip,
  output csr_word_t   old_csr_val,
  output logic        invalid_csr,
  output csr_word_t   curr_mstatus,
  output csr_word_t   curr_mie,
  output csr_word_t   curr_mip,
  output csr_word_t   curr_mtvec,
  output csr_word_t   curr_mepc,
  output csr_word_t   curr_mcause
);

  csr_word_t              nxt_csr_val;
  logic                   wr_en, invalid_priv, invalid_addr;
  csr_word_t              mscratch, mtval;
  logic [2*CSR_WIDTH-1:0] cycle_full, instret_full;
  csr_word_t              mcounteren, mcountinhibit;

  csr_access_unit access_i (
    .csr_addr, .csr_op, .read_only, .write_valid, .new_csr_val,
    .old_csr_val, .curr_priv, .nxt_csr_val, .wr_en, .invalid_priv
  );

  csr_machine_regs regs_i (
    .CLK, .nRST, .csr_addr, .wr_en, .nxt_csr_val, .new_csr_val,
    .inject_mstatus, .inject_mepc, .inject_mcause, .inject_mtval, .inject_mip,
    .next_mstatus, .next_mepc, .next_mcause, .next_mtval, .next_mip,
    .mstatus(curr_mstatus), .mtvec(curr_mtvec), .mie(curr_mie), .mip(curr_mip),
    .mscratch, .mepc(curr_mepc), .mcause(curr_mcause), .mtval
  );

  csr_counters counters_i (
    .CLK, .nRST, .csr_addr, .wr_en, .nxt_csr_val, .inst_ret,
    .cycle_full, .instret_full, .mcounteren, .mcountinhibit
  );

  csr_read_mux #(.HART_ID(HART_ID)) read_i (
    .csr_addr, .csr_op, .curr_priv,
    .mstatus(curr_mstatus), .mtvec(curr_mtvec), .mie(curr_mie), .mip(curr_mip),
    .mscratch, .mepc(curr_mepc), .mcause(curr_mcause), .mtval,
    .cycle_full, .instret_full, .mcounteren, .mcountinhibit,
    .old_csr_val, .invalid_addr
  );

  assign invalid_csr = invalid_priv | invalid_addr; // Either check rejects the access

endmodule

/* bench/csr_file_tb.sv */
module csr_file_tb import csr_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RST_CYCLES = 16;
  localparam int POLL_LIMIT = 20;
  localparam csr_word_t STATUS_FIELDS = 32'h0022_1888; // MIE, MPIE, MPP, MPRV, TW
  localparam csr_word_t M_INT_BITS = 32'h0000_0888;    // MSI, MTI, MEI
  localparam csr_addr_t UNKNOWN_ADDR = 12'h7C0;
  localparam csr_addr_t TRAP_ADDRS [8] = '{MSCRATCH_ADDR, MEPC_ADDR, MTVAL_ADDR, MCAUSE_ADDR,
                                           MTVEC_ADDR, MIE_ADDR, MIP_ADDR, MSTATUS_ADDR};

  logic        CLK = 1'b0;
  logic        nRST;
  csr_addr_t   csr_addr;
  csr_op_t     csr_op;
  logic        read_only, write_valid, inst_ret;
  csr_word_t   new_csr_val;
  priv_level_t curr_priv;
  logic        inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip;
  csr_word_t   next_mstatus, next_mepc, next_mcause, next_mtval, next_mip;
  csr_word_t   old_csr_val, curr_mstatus, curr_mie, curr_mip;
  csr_word_t   curr_mtvec, curr_mepc, curr_mcause;
  logic        invalid_csr;

  int          seed;
  int          error_count;
  logic        expect_en;    // Compare process armed for this cycle
  string       expect_name;
  csr_word_t   expect_val;
  logic        expect_inv;

  csr_file_top #(.HART_ID(5)) dut_i (.*);

  always #2 CLK = ~CLK;

  // Legal value of a trap register after one CSR operation
  function automatic csr_word_t expected_write(csr_addr_t addr, csr_op_t op,
                                               csr_word_t old_val, csr_word_t new_val);
    csr_word_t raw;
    csr_word_t result;
    case (op)
      CSR_WRITE: raw = new_val;
      CSR_SET:   raw = old_val | new_val;
      CSR_CLEAR: raw = old_val & ~new_val;
      default:   raw = old_val;
    endcase
    result = raw;
    case (addr)
      MSTATUS_ADDR: begin
        result = raw & STATUS_FIELDS;
        if (new_val[12:11] == 2'd1 || new_val[12:11] == 2'd2) result[12:11] = 2'd0; // To U
      end
      MTVEC_ADDR: if (raw[1:0] > 2'd1) result[1:0] = 2'd0; // Reserved mode to direct
      MIE_ADDR, MIP_ADDR: result = raw & M_INT_BITS;
      default: ;
    endcase
    return result;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      error_count++;
      fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // Register outputs that go straight to the core
  task automatic check_trap_output(input csr_addr_t addr, input csr_word_t expected);
    case (addr)
      MSTATUS_ADDR: check_value("curr_mstatus", 64'(curr_mstatus), 64'(expected));
      MIE_ADDR:     check_value("curr_mie", 64'(curr_mie), 64'(expected));
      MIP_ADDR:     check_value("curr_mip", 64'(curr_mip), 64'(expected));
      MTVEC_ADDR:   check_value("curr_mtvec", 64'(curr_mtvec), 64'(expected));
      MEPC_ADDR:    check_value("curr_mepc", 64'(curr_mepc), 64'(expected));
      MCAUSE_ADDR:  check_value("curr_mcause", 64'(curr_mcause), 64'(expected));
      default: ;
    endcase
  endtask

  always @(negedge CLK) begin
    if (expect_en) begin
      check_value({expect_name, " value"}, 64'(old_csr_val), 64'(expect_val));
      check_value({expect_name, " invalid_csr"}, 64'(invalid_csr), 64'(expect_inv));
    end
  end

  task automatic idle_inputs();
    csr_op = CSR_NONE;
    write_valid = 1'b0;
    read_only = 1'b0;
    new_csr_val = '0;
    inst_ret = 1'b0;
    inject_mstatus = 1'b0;
    inject_mepc = 1'b0;
    inject_mcause = 1'b0;
    inject_mtval = 1'b0;
    inject_mip = 1'b0;
  endtask

  // One access cycle, sampled mid-cycle
  task automatic csr_cycle(input csr_addr_t addr, input csr_op_t op, input csr_word_t val,
                           input logic ro, input logic commit,
                           output csr_word_t rd_val, output logic rd_inv);
    csr_addr = addr;
    csr_op = op;
    new_csr_val = val;
    read_only = ro;
    write_valid = commit;
    @(negedge CLK);
    rd_val = old_csr_val;
    rd_inv = invalid_csr;
    @(posedge CLK);
    #1;
    idle_inputs();
  endtask

  task automatic read_csr(input csr_addr_t addr, output csr_word_t rd_val);
    logic rd_inv;
    csr_cycle(addr, CSR_SET, '0, 1'b1, 1'b0, rd_val, rd_inv);
  endtask

  task automatic write_csr(input csr_addr_t addr, input csr_op_t op, input csr_word_t val);
    csr_word_t rd_val;
    logic      rd_inv;
    csr_cycle(addr, op, val, 1'b0, 1'b1, rd_val, rd_inv);
    check_value($sformatf("invalid_csr on write to 0x%h", addr), 64'(rd_inv), 64'(0));
  endtask

  task automatic expect_read(input csr_addr_t addr, input string name, input csr_word_t value,
                             input logic inv);
    csr_word_t rd_val;
    logic      rd_inv;
    expect_name = name;
    expect_val = value;
    expect_inv = inv;
    expect_en = 1'b1;
    csr_cycle(addr, CSR_SET, '0, 1'b1, 1'b0, rd_val, rd_inv);
    expect_en = 1'b0;
  endtask

  task automatic apply_and_check(input csr_addr_t addr, input csr_op_t op, input csr_word_t val);
    csr_word_t old_val;
    csr_word_t exp_val;
    read_csr(addr, old_val);
    write_csr(addr, op, val);
    exp_val = expected_write(addr, op, old_val, val);
    expect_read(addr, $sformatf("csr 0x%h after %s", addr, op.name()), exp_val, 1'b0);
    check_trap_output(addr, exp_val);
  endtask

  // CSR write and trap injection on the same register in one cycle
  task automatic inject_over_write(input csr_addr_t addr, input csr_word_t csr_val,
                                   input csr_word_t inj_val);
    csr_addr = addr;
    csr_op = CSR_WRITE;
    new_csr_val = csr_val;
    write_valid = 1'b1;
    case (addr)
      MEPC_ADDR: begin
        inject_mepc = 1'b1;
        next_mepc = inj_val;
      end
      MCAUSE_ADDR: begin
        inject_mcause = 1'b1;
        next_mcause = inj_val;
      end
      MTVAL_ADDR: begin
        inject_mtval = 1'b1;
        next_mtval = inj_val;
      end
      MSTATUS_ADDR: begin
        inject_mstatus = 1'b1;
        next_mstatus = inj_val;
      end
      default: begin
        inject_mip = 1'b1;
        next_mip = inj_val;
      end
    endcase
    @(posedge CLK);
    #1;
    idle_inputs();
    expect_read(addr, $sformatf("csr 0x%h after injection", addr), inj_val, 1'b0);
    check_trap_output(addr, inj_val);
  endtask

  initial begin
    csr_word_t   rd_a, rd_b, hi_w, lo_w, hi_now, lo_now, base;
    logic        inv;
    csr_op_t     op;
    int          polls, n_pulses;
    seed = 38379;
    error_count = 0;
    expect_en = 1'b0;
    expect_name = "";
    expect_val = '0;
    expect_inv = 1'b0;
    nRST = 1'b0;
    csr_addr = '0;
    curr_priv = M_MODE;
    {next_mstatus, next_mepc, next_mcause, next_mtval, next_mip} = '0;
    idle_inputs();
    repeat (RST_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;

    expect_read(MSTATUS_ADDR, "mstatus after reset", 32'h0020_0000, 1'b0);
    check_trap_output(MSTATUS_ADDR, 32'h0020_0000);
    expect_read(MCOUNTEREN_ADDR, "mcounteren after reset", 32'hffff_ffff, 1'b0);
    expect_read(MHARTID_ADDR, "mhartid", 32'd5, 1'b0);
    csr_cycle(UNKNOWN_ADDR, CSR_NONE, '0, 1'b0, 1'b0, rd_a, inv);
    check_value("invalid_csr with no operation", 64'(inv), 64'(0));

    // Directed legalization corners
    apply_and_check(MSTATUS_ADDR, CSR_WRITE, 32'h0000_1088); // MPP reserved
    apply_and_check(MSTATUS_ADDR, CSR_WRITE, 32'hffff_ffff);
    apply_and_check(MSTATUS_ADDR, CSR_CLEAR, 32'h0022_0800); // MPP field S
    apply_and_check(MTVEC_ADDR, CSR_WRITE, 32'h8000_0102);
    apply_and_check(MTVEC_ADDR, CSR_WRITE, 32'h8000_0103);
    apply_and_check(MTVEC_ADDR, CSR_WRITE, 32'h0000_1001);
    apply_and_check(MTVEC_ADDR, CSR_SET, 32'h0000_0002);
    apply_and_check(MIE_ADDR, CSR_WRITE, 32'hffff_ffff);
    apply_and_check(MIP_ADDR, CSR_WRITE, 32'haaaa_5555);
    for (int i = 0; i < 48; i++) begin
      case ($unsigned($random(seed)) % 3)
        0:       op = CSR_WRITE;
        1:       op = CSR_SET;
        default: op = CSR_CLEAR;
      endcase
      apply_and_check(TRAP_ADDRS[$unsigned($random(seed)) % 8], op, $random(seed));
    end

    write_csr(MSCRATCH_ADDR, CSR_WRITE, 32'h1234_5678);
    curr_priv = U_MODE;
    csr_cycle(MSCRATCH_ADDR, CSR_WRITE, 32'hdead_beef, 1'b0, 1'b1, rd_a, inv);
    check_value("invalid_csr on U-mode mscratch write", 64'(inv), 64'(1));
    curr_priv = M_MODE;
    expect_read(MSCRATCH_ADDR, "mscratch after denied write", 32'h1234_5678, 1'b0);
    csr_cycle(CYCLE_ADDR, CSR_WRITE, 32'h1, 1'b0, 1'b1, rd_a, inv);
    check_value("invalid_csr on read-only write", 64'(inv), 64'(1));
    csr_cycle(UNKNOWN_ADDR, CSR_SET, '0, 1'b1, 1'b0, rd_a, inv);
    check_value("invalid_csr on unknown address", 64'(inv), 64'(1));

    inject_over_write(MEPC_ADDR, $random(seed), $random(seed));
    inject_over_write(MCAUSE_ADDR, $random(seed), $random(seed));
    inject_over_write(MTVAL_ADDR, $random(seed), $random(seed));
    inject_over_write(MSTATUS_ADDR, $random(seed), $random(seed));
    inject_over_write(MIP_ADDR, $random(seed), $random(seed));

    write_csr(MCOUNTINHIBIT_ADDR, CSR_WRITE, 32'h5); // Both counters held
    read_csr(MCYCLE_ADDR, rd_a);
    read_csr(MCYCLE_ADDR, rd_b);
    check_value("mcycle while inhibited", 64'(rd_b), 64'(rd_a));
    hi_w = $random(seed);
    lo_w = $random(seed) & 32'h0fff_ffff; // No carry into the high half
    write_csr(MCYCLEH_ADDR, CSR_WRITE, hi_w);
    write_csr(MCYCLE_ADDR, CSR_WRITE, lo_w);
    write_csr(MCOUNTINHIBIT_ADDR, CSR_CLEAR, 32'h1);
    polls = 0;
    hi_now = hi_w;
    lo_now = lo_w;
    while ({hi_now, lo_now} <= {hi_w, lo_w}) begin
      if (polls == POLL_LIMIT) begin
        fail_run("Timeout waiting for mcycle to count past the written value");
      end
      read_csr(MCYCLEH_ADDR, hi_now);
      read_csr(MCYCLE_ADDR, lo_now);
      polls++;
    end
    check_value("mcycleh after counting", 64'(hi_now), 64'(hi_w));

    write_csr(MCOUNTINHIBIT_ADDR, CSR_WRITE, 32'h1); // Only instret counts
    read_csr(MINSTRET_ADDR, base);
    n_pulses = 4 + ($unsigned($random(seed)) % 8);
    for (int i = 0; i < n_pulses; i++) begin
      inst_ret = 1'b1;
      @(posedge CLK);
      #1;
      inst_ret = 1'b0;
      @(posedge CLK);
      #1;
    end
    polls = 0;
    rd_a = base;
    while (rd_a < base + csr_word_t'(n_pulses)) begin
      if (polls == POLL_LIMIT) fail_run("Timeout waiting for minstret to reach the pulse count");
      read_csr(MINSTRET_ADDR, rd_a);
      polls++;
    end
    check_value("minstret after pulses", 64'(rd_a), 64'(base + csr_word_t'(n_pulses)));

    write_csr(MCOUNTEREN_ADDR, CSR_CLEAR, 32'h5);
    expect_read(MCOUNTEREN_ADDR, "mcounteren after clear", 32'hffff_fffa, 1'b0);
    curr_priv = U_MODE;
    csr_cycle(CYCLE_ADDR, CSR_SET, '0, 1'b1, 1'b0, rd_a, inv);
    check_value("invalid_csr on disabled cycle", 64'(inv), 64'(1));
    csr_cycle(INSTRET_ADDR, CSR_SET, '0, 1'b1, 1'b0, rd_a, inv);
    check_value("invalid_csr on disabled instret", 64'(inv), 64'(1));
    curr_priv = M_MODE;
    write_csr(MCOUNTEREN_ADDR, CSR_SET, 32'h5);
    read_csr(MCYCLE_ADDR, rd_a);
    read_csr(MINSTRET_ADDR, rd_b);
    curr_priv = U_MODE;
    expect_read(CYCLE_ADDR, "cycle from U mode", rd_a, 1'b0);
    expect_read(INSTRET_ADDR, "instret from U mode", rd_b, 1'b0);
    curr_priv = M_MODE;

    if (error_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      fail_run("Errors were counted during the run");
    end
  end

endmodule

/* csr_file.f */
verilog/csr_pkg.sv
verilog/csr_access_unit.sv
verilog/csr_machine_regs.sv
verilog/csr_counters.sv
verilog/csr_read_mux.sv
verilog/csr_file_top.sv
bench/csr_file_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the CSR file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=csr_file_sim

verilator --binary --timing -Mdir "$BUILD_DIR" --top-module csr_file_tb \
  -f csr_file.f -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Test failed" "$LOG_FILE"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

echo "Simulation passed"
exit 0
